/* filelist.f */
logic/tx_cpl_pkg.sv
logic/tx_cpl_tracker.sv
logic/tx_host_regs.sv
logic/tx_irq_gen.sv
logic/tx_cpl_top.sv
sim/tx_cpl_tb.sv

/* Makefile */
# Verilator build and run for the tx completion interrupt path

VERILATOR ?= verilator
TOP       ?= tx_cpl_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Test failed
VFLAGS    ?= --binary --timing --assert -j 0

# sources come from the file list, +incdir+ lines skipped
SRCS    := $(filter-out +%,$(shell cat $(FILELIST)))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# nonzero exit or the fail line in the log fails the target
run: $(SIM_BIN)
	@status=0; ./$(SIM_BIN) > $(LOG) 2>&1 || status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported a failure, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* sim/tx_cpl_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module tx_cpl_tb
    import tx_cpl_pkg::*;
();

    ////////////////////////////////////////////////////////////
    // run length

    localparam int RING_BYTES    = 4096;
    localparam int CLK_PERIOD    = 40;   // ns
    localparam int DRV_DLY       = 2;    // ns past the rising edge
    localparam int RESET_CYCLES  = 10;
    localparam int BURST_FRAMES  = 48;   // wraps the ring several times over
    localparam int REG_LOOPS     = 8;
    localparam int IRQ_WAIT      = 8;    // cycles allowed for send_irq to settle
    localparam int PHASE_CYCLES  = RESET_CYCLES + 20 + BURST_FRAMES * 3 + 40 + 120
                                   + REG_LOOPS * 12;
    localparam int MARGIN_CYCLES = 100;

    logic                  clk;
    logic                  rst;
    logic                  frame_done;
    logic [LEN_W-1:0]      frame_len;
    logic                  reg_wr;
    logic                  reg_rd;
    logic [REG_ADDR_W-1:0] reg_addr;
    logic [PTR_W-1:0]      reg_wdata;
    logic [PTR_W-1:0]      reg_rdata;
    logic                  reg_rdata_vld;
    logic [PTR_W-1:0]      hw_ptr;
    logic                  send_irq;

    int          errors;
    int          frames;
    int          reads;
    logic [31:0] lcg_state;

    tx_cpl_top #(
        .RING_BYTES (RING_BYTES)
    ) i_tx_cpl_top (
        .clk           (clk),
        .rst           (rst),
        .frame_done    (frame_done),
        .frame_len     (frame_len),
        .reg_wr        (reg_wr),
        .reg_rd        (reg_rd),
        .reg_addr      (reg_addr),
        .reg_wdata     (reg_wdata),
        .reg_rdata     (reg_rdata),
        .reg_rdata_vld (reg_rdata_vld),
        .hw_ptr        (hw_ptr),
        .send_irq      (send_irq)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // helpers

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [LEN_W-1:0] random_len();
        return LEN_W'((next_random() >> 8) % 32'd1518 + 32'd1);  // 1 to 1518
    endfunction

    // header plus payload padded up to the next 8 bytes
    function automatic logic [PTR_W-1:0] record_bytes(input logic [LEN_W-1:0] len);
        int padded;
        padded = (int'(len) + CPL_ALIGN - 1) / CPL_ALIGN * CPL_ALIGN;
        return PTR_W'(CPL_HDR_BYTES + padded);
    endfunction

    // control word with junk in the reserved bits
    function automatic logic [PTR_W-1:0] ctrl_word(input logic en);
        tx_reg_word_u w;
        w.ptr         = {next_random(), next_random()};
        w.ctrl.irq_en = en;
        return w.ptr;
    endfunction

    function automatic logic [PTR_W-1:0] expected_read(input logic [REG_ADDR_W-1:0] addr,
                                                       input logic [PTR_W-1:0] hw,
                                                       input logic [PTR_W-1:0] sw,
                                                       input logic en);
        tx_reg_word_u w;
        w = '0;
        if (addr == REG_SW_PTR) begin
            w.ptr = sw;
        end else if (addr == REG_CTRL) begin
            w.ctrl.irq_en = en;  // reserved part stays zero
        end else if (addr == REG_HW_PTR) begin
            w.ptr = hw;
        end
        return w.ptr;
    endfunction

    task automatic flag_error(input string msg);
        errors++;
        $display("** Error: %0t ns: %s", $time, msg);
    endtask

    ////////////////////////////////////////////////////////////
    // reference model, same register timing as the DUT

    logic [PTR_W-1:0] exp_hw_ptr;
    logic [PTR_W-1:0] exp_sw_ptr;
    logic             exp_irq_en;
    logic [PTR_W-1:0] exp_rdata;    // what a read this cycle should return
    logic             sw_catch_up;  // host write that closes the gap

    always @(posedge clk) begin
        if (rst) begin
            exp_hw_ptr <= '0;
            exp_sw_ptr <= '0;
            exp_irq_en <= 1'b0;
        end else begin
            if (frame_done) begin
                exp_hw_ptr <= (exp_hw_ptr + record_bytes(frame_len)) % PTR_W'(RING_BYTES);
            end
            if (reg_wr && reg_addr == REG_SW_PTR) begin
                exp_sw_ptr <= reg_wdata;
            end
            if (reg_wr && reg_addr == REG_CTRL) begin
                exp_irq_en <= reg_wdata[0];
            end
        end
    end

    assign exp_rdata   = expected_read(reg_addr, exp_hw_ptr, exp_sw_ptr, exp_irq_en);
    assign sw_catch_up = send_irq && reg_wr && reg_addr == REG_SW_PTR && !frame_done
                         && reg_wdata == exp_hw_ptr && exp_sw_ptr != exp_hw_ptr;

    ////////////////////////////////////////////////////////////
    // checks

    a_reset_quiet: assert property (@(posedge clk)
        $past(rst) |-> !send_irq && !reg_rdata_vld && hw_ptr == '0
    ) else flag_error("outputs not cleared by reset");

    a_hw_ptr_model: assert property (@(posedge clk) disable iff (rst)
        hw_ptr == exp_hw_ptr
    ) else flag_error("hw_ptr differs from the record model");

    a_read_valid: assert property (@(posedge clk) disable iff (rst)
        reg_rdata_vld == $past(reg_rd)
    ) else flag_error("reg_rdata_vld not one cycle after reg_rd");

    a_read_data: assert property (@(posedge clk) disable iff (rst)
        $past(reg_rd) |-> reg_rdata == $past(exp_rdata)
    ) else flag_error("reg_rdata wrong for the address read");

    // frame at t, enabled and idle at t+1, irq up at t+2
    a_irq_after_frame: assert property (@(posedge clk) disable iff (rst)
        $past(frame_done, 2) && $past(exp_irq_en && !send_irq) |-> send_irq
    ) else flag_error("send_irq not raised two cycles after frame_done");

    a_irq_hold: assert property (@(posedge clk) disable iff (rst)
        $past(send_irq && exp_hw_ptr != exp_sw_ptr) |-> send_irq
    ) else flag_error("send_irq dropped with pointers apart");

    a_irq_drop: assert property (@(posedge clk) disable iff (rst)
        $past(sw_catch_up, 2) |-> $past(send_irq) && !send_irq
    ) else flag_error("send_irq not dropped two cycles after sw_ptr caught up");

    a_irq_quiet_disabled: assert property (@(posedge clk) disable iff (rst)
        $past(!send_irq && !exp_irq_en) |-> !send_irq
    ) else flag_error("send_irq raised with irq_en clear");

    // a rise needs an enabled frame two or three cycles back
    a_irq_rise_cause: assert property (@(posedge clk) disable iff (rst)
        send_irq && !$past(send_irq) |-> $past(exp_irq_en)
            && ($past(frame_done, 2) || ($past(frame_done, 3) && $past(exp_irq_en, 2)))
    ) else flag_error("send_irq rose without an enabled frame");

    ////////////////////////////////////////////////////////////
    // stimulus tasks

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clk);
        #DRV_DLY;
    endtask

    task automatic send_frame(input logic [LEN_W-1:0] len);
        @(posedge clk);
        #DRV_DLY;
        frame_done = 1'b1;
        frame_len  = len;
        frames++;
        @(posedge clk);
        #DRV_DLY;
        frame_done = 1'b0;
    endtask

    // random gaps of 0 to 2 cycles, 0 gives back to back strobes
    task automatic send_burst(input int n);
        int gap;
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            #DRV_DLY;
            frame_done = 1'b1;
            frame_len  = random_len();
            frames++;
            gap = int'((next_random() >> 4) % 32'd3);
            repeat (gap) begin
                @(posedge clk);
                #DRV_DLY;
                frame_done = 1'b0;
            end
        end
        @(posedge clk);
        #DRV_DLY;
        frame_done = 1'b0;
    endtask

    task automatic write_reg(input logic [REG_ADDR_W-1:0] addr, input logic [PTR_W-1:0] data);
        @(posedge clk);
        #DRV_DLY;
        reg_wr    = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        @(posedge clk);
        #DRV_DLY;
        reg_wr = 1'b0;
    endtask

    task automatic read_reg(input logic [REG_ADDR_W-1:0] addr);
        @(posedge clk);
        #DRV_DLY;
        reg_rd   = 1'b1;
        reg_addr = addr;
        reads++;
        @(posedge clk);
        #DRV_DLY;
        reg_rd = 1'b0;
    endtask

    task automatic wait_send_irq(input logic level);
        int waited;
        waited = 0;
        while (send_irq !== level && waited < IRQ_WAIT) begin
            @(posedge clk);
            #DRV_DLY;
            waited++;
        end
        if (send_irq !== level) begin
            errors++;
            $display("send_irq did not reach %b within %0d cycles", level, IRQ_WAIT);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // phases

    initial begin
        lcg_state  = 32'hbc45;
        errors     = 0;
        frames     = 0;
        reads      = 0;
        rst        = 1'b1;
        frame_done = 1'b0;
        frame_len  = '0;
        reg_wr     = 1'b0;
        reg_rd     = 1'b0;
        reg_addr   = '0;
        reg_wdata  = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRV_DLY;
        rst = 1'b0;
        idle_cycles(3);

        read_reg(REG_HW_PTR);  // all zero out of reset
        read_reg(REG_SW_PTR);
        read_reg(REG_CTRL);

        send_burst(BURST_FRAMES);  // irq still disabled here
        read_reg(REG_HW_PTR);

        write_reg(REG_CTRL, ctrl_word(1'b1));
        read_reg(REG_CTRL);
        idle_cycles(4);
        send_frame(random_len());
        wait_send_irq(1'b1);

        write_reg(REG_SW_PTR, exp_hw_ptr + PTR_W'(4));  // off by a few, irq stays
        read_reg(REG_SW_PTR);
        for (int i = 0; i < 3; i++) begin
            send_frame(random_len());
        end
        idle_cycles(3);
        write_reg(REG_SW_PTR, exp_hw_ptr);  // nothing in flight
        wait_send_irq(1'b0);

        send_frame(random_len());
        wait_send_irq(1'b1);
        write_reg(REG_CTRL, ctrl_word(1'b0));  // disable while raised
        idle_cycles(4);
        write_reg(REG_SW_PTR, exp_hw_ptr);
        wait_send_irq(1'b0);
        send_burst(6);  // lost completions
        idle_cycles(4);
        write_reg(REG_CTRL, ctrl_word(1'b1));
        idle_cycles(6);
        send_frame(random_len());
        wait_send_irq(1'b1);
        write_reg(REG_SW_PTR, exp_hw_ptr);
        wait_send_irq(1'b0);

        for (int i = 0; i < REG_LOOPS; i++) begin
            write_reg(REG_SW_PTR, {next_random(), next_random()});
            read_reg(REG_SW_PTR);
            write_reg(REG_CTRL, ctrl_word(1'(next_random() >> 16)));
            read_reg(REG_CTRL);
            read_reg(2'd3);  // unmapped
        end
        idle_cycles(4);

        $display("frames %0d, reads %0d, errors %0d", frames, reads, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #((PHASE_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, stimulus never finished",
                 PHASE_CYCLES + MARGIN_CYCLES);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* logic/tx_cpl_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tx_cpl_top
    import tx_cpl_pkg::*;
#(
    parameter int RING_BYTES = 4096  // completion ring size in bytes
) (
    input  wire logic                  clk,
    input  wire logic                  rst,

    // from the tx mac side
    input  wire logic                  frame_done,
    input  wire logic [LEN_W-1:0]      frame_len,

    // host register strobes
    input  wire logic                  reg_wr,
    input  wire logic                  reg_rd,
    input  wire logic [REG_ADDR_W-1:0] reg_addr,
    input  wire logic [PTR_W-1:0]      reg_wdata,
    output logic      [PTR_W-1:0]      reg_rdata,
    output logic                       reg_rdata_vld,

    // to the completion writer and pcie core
    output logic      [PTR_W-1:0]      hw_ptr,
    output logic                       send_irq
);

    ////////////////////////////////////////////////////////////
    // internal nets

    logic             data_rdy;  // tracker to irq fsm
    logic [PTR_W-1:0] sw_ptr;    // regs to irq fsm
    logic             irq_en;

    ////////////////////////////////////////////////////////////
    // completion pointer

    tx_cpl_tracker #(
        .RING_BYTES (RING_BYTES)
    ) i_tx_cpl_tracker (
        .clk        (clk),
        .rst        (rst),
        .frame_done (frame_done),
        .frame_len  (frame_len),
        .hw_ptr     (hw_ptr),
        .data_rdy   (data_rdy)
    );

    ////////////////////////////////////////////////////////////
    // host registers

    tx_host_regs i_tx_host_regs (
        .clk           (clk),
        .rst           (rst),
        .reg_wr        (reg_wr),
        .reg_rd        (reg_rd),
        .reg_addr      (reg_addr),
        .reg_wdata     (reg_wdata),
        .reg_rdata     (reg_rdata),
        .reg_rdata_vld (reg_rdata_vld),
        .hw_ptr        (hw_ptr),
        .sw_ptr        (sw_ptr),
        .irq_en        (irq_en)
    );

    ////////////////////////////////////////////////////////////
    // interrupt request

    tx_irq_gen i_tx_irq_gen (
        .clk      (clk),
        .rst      (rst),
        .data_rdy (data_rdy),
        .irq_en   (irq_en),
        .hw_ptr   (hw_ptr),
        .sw_ptr   (sw_ptr),
        .send_irq (send_irq)  // level, held until sw_ptr catches up
    );

endmodule

`default_nettype wire

/* logic/tx_irq_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tx_irq_gen
    import tx_cpl_pkg::*;
(
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             data_rdy,  // one pulse per completion
    input  wire logic             irq_en,
    input  wire logic [PTR_W-1:0] hw_ptr,
    input  wire logic [PTR_W-1:0] sw_ptr,
    output logic                  send_irq   // level to the msi logic
);

    ////////////////////////////////////////////////////////////
    // interrupt fsm

    localparam logic [1:0] ST_INIT  = 2'd0;
    localparam logic [1:0] ST_IDLE  = 2'd1;
    localparam logic [1:0] ST_ARMED = 2'd2;  // irq up, waiting for host

    logic [1:0] state;
    logic       data_rdy_q;  // pulse seen last cycle
    logic       ptr_eq;

    assign ptr_eq   = (hw_ptr == sw_ptr);
    assign send_irq = (state == ST_ARMED);

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= ST_INIT;
            data_rdy_q <= 1'b0;
        end else begin
            data_rdy_q <= data_rdy & irq_en;  // disabled pulses are lost
            case (state)
                ST_INIT: begin
                    data_rdy_q <= 1'b0;
                    state      <= ST_IDLE;
                end
                ST_IDLE: begin
                    if (irq_en && (data_rdy || data_rdy_q)) begin
                        state <= ST_ARMED;
                    end
                end
                ST_ARMED: begin
                    if (ptr_eq) begin  // host caught up
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_INIT;
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // checks

    // raised only from idle, enabled, with a fresh or captured pulse
    a_irq_rise: assert property (
        @(posedge clk) disable iff (rst)
        ($rose(send_irq) && !$past(rst)) |->
            $past(state == ST_IDLE && irq_en && (data_rdy || data_rdy_q))
    ) else $error("tx_irq_gen: send_irq rose without an enabled completion");

    // dropped only once the host pointer matched
    a_irq_fall: assert property (
        @(posedge clk) disable iff (rst)
        ($fell(send_irq) && !$past(rst)) |-> $past(ptr_eq)
    ) else $error("tx_irq_gen: send_irq fell with pointers apart");

endmodule

`default_nettype wire

/* logic/tx_host_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module tx_host_regs
    import tx_cpl_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  rst,

    // host strobes
    input  wire logic                  reg_wr,
    input  wire logic                  reg_rd,
    input  wire logic [REG_ADDR_W-1:0] reg_addr,
    input  wire logic [PTR_W-1:0]      reg_wdata,
    output logic      [PTR_W-1:0]      reg_rdata,
    output logic                       reg_rdata_vld,  // one cycle after reg_rd

    // ring state
    input  wire logic [PTR_W-1:0]      hw_ptr,   // read back only
    output logic      [PTR_W-1:0]      sw_ptr,   // host consumed position
    output logic                       irq_en
);

    ////////////////////////////////////////////////////////////
    // write side

    tx_reg_word_u wr_word;

    assign wr_word = reg_wdata;  // same bits, two views

    always_ff @(posedge clk) begin
        if (rst) begin
            sw_ptr <= '0;
            irq_en <= 1'b0;
        end else if (reg_wr) begin
            case (reg_addr)
                REG_SW_PTR: begin
                    sw_ptr <= wr_word.ptr;
                end
                REG_CTRL: begin
                    irq_en <= wr_word.ctrl.irq_en;  // reserved bits dropped
                end
                default: begin
                    // hw_ptr is read only, address 3 unmapped
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // read side

    tx_reg_word_u rd_word;

    always_comb begin
        rd_word = '0;
        case (reg_addr)
            REG_SW_PTR: begin
                rd_word.ptr = sw_ptr;
            end
            REG_CTRL: begin
                rd_word.ctrl.irq_en = irq_en;  // rsvd stays zero
            end
            REG_HW_PTR: begin
                rd_word.ptr = hw_ptr;
            end
            default: begin
                rd_word = '0;
            end
        endcase
    end

    // data held between reads
    always_ff @(posedge clk) begin
        if (reg_rd) begin
            reg_rdata <= rd_word;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            reg_rdata_vld <= 1'b0;
        end else begin
            reg_rdata_vld <= reg_rd;
        end
    end

    ////////////////////////////////////////////////////////////
    // checks

    // host issues one access per cycle
    a_no_wr_rd_overlap: assert property (
        @(posedge clk) disable iff (rst)
        !(reg_wr && reg_rd)
    ) else $error("tx_host_regs: reg_wr and reg_rd in the same cycle");

endmodule

`default_nettype wire

/* logic/tx_cpl_tracker.sv */
`timescale 1ns/1ps
`default_nettype none

module tx_cpl_tracker
    import tx_cpl_pkg::*;
#(
    parameter int RING_BYTES = 4096  // ring size in bytes, power of two
) (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             frame_done,  // one strobe per sent frame
    input  wire logic [LEN_W-1:0] frame_len,   // valid with frame_done
    output logic      [PTR_W-1:0] hw_ptr,
    output logic                  data_rdy     // new pointer this cycle
);

    ////////////////////////////////////////////////////////////
    // constants

    localparam logic [PTR_W-1:0] RING_MASK  = PTR_W'(RING_BYTES - 1);
    localparam logic [PTR_W-1:0] ALIGN_MASK = ~PTR_W'(CPL_ALIGN - 1);
    localparam logic [PTR_W-1:0] ALIGN_ADD  = PTR_W'(CPL_ALIGN - 1);
    localparam logic [PTR_W-1:0] HDR_BYTES  = PTR_W'(CPL_HDR_BYTES);

    // the wrap below only works with a power of two ring
    if (RING_BYTES < 2048 || (RING_BYTES & (RING_BYTES - 1)) != 0) begin : g_ring_check
        $error("tx_cpl_tracker: RING_BYTES must be a power of two, at least 2048");
    end

    ////////////////////////////////////////////////////////////
    // record size and next pointer

    logic [PTR_W-1:0] len_ext;
    logic [PTR_W-1:0] rec_bytes;   // header plus padded payload
    logic [PTR_W-1:0] hw_ptr_nxt;

    assign len_ext    = PTR_W'(frame_len);
    assign rec_bytes  = HDR_BYTES + ((len_ext + ALIGN_ADD) & ALIGN_MASK);
    assign hw_ptr_nxt = (hw_ptr + rec_bytes) & RING_MASK;  // wrap at ring end

    always_ff @(posedge clk) begin
        if (rst) begin
            hw_ptr   <= '0;
            data_rdy <= 1'b0;
        end else begin
            data_rdy <= frame_done;  // pulse lines up with new pointer
            if (frame_done) begin
                hw_ptr <= hw_ptr_nxt;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // checks

    // empty frames never reach the completion path
    a_len_nonzero: assert property (
        @(posedge clk) disable iff (rst)
        frame_done |-> frame_len != '0
    ) else $error("tx_cpl_tracker: frame_done with zero frame_len");

    // pointer stays record aligned and inside the ring
    a_ptr_in_ring: assert property (
        @(posedge clk) disable iff (rst)
        ((hw_ptr & ALIGN_ADD) == '0) && (hw_ptr < PTR_W'(RING_BYTES))
    ) else $error("tx_cpl_tracker: hw_ptr misaligned or outside ring");

endmodule

`default_nettype wire

/* logic/tx_cpl_pkg.sv */
`default_nettype none

package tx_cpl_pkg;

    ////////////////////////////////////////////////////////////
    // widths

    localparam int PTR_W      = 64;  // ring pointers and register data
    localparam int LEN_W      = 16;  // frame length in bytes
    localparam int REG_ADDR_W = 2;

    ////////////////////////////////////////////////////////////
    // host register map, address 3 unmapped

    localparam logic [REG_ADDR_W-1:0] REG_SW_PTR = 2'd0;  // host consumed position
    localparam logic [REG_ADDR_W-1:0] REG_CTRL   = 2'd1;  // control word
    localparam logic [REG_ADDR_W-1:0] REG_HW_PTR = 2'd2;  // read only

    ////////////////////////////////////////////////////////////
    // completion record sizing

    localparam int CPL_HDR_BYTES = 8;  // record header ahead of each frame
    localparam int CPL_ALIGN     = 8;  // records start on 8 byte boundaries

    // control word, only bit 0 is live
    typedef struct packed {
        logic [PTR_W-2:0] rsvd;    // reads as zero
        logic             irq_en;
    } tx_ctrl_t;

    // one register data word, seen as a pointer or as control
    typedef union packed {
        logic [PTR_W-1:0] ptr;
        tx_ctrl_t         ctrl;
    } tx_reg_word_u;

endpackage

`default_nettype wire
